// File: rtl/ipguPkg.sv
package ipguPkg;

    ////////////////////
    // Frame geometry
    ////////////////////

    // Row length and row count of the full frame
    localparam int FRAME_W = 16;
    localparam int FRAME_H = 16;

    // Counter widths for the raster scan
    localparam int COL_W = 4;
    localparam int ROW_W = 4;

    ////////////////////
    // Data widths
    ////////////////////

    localparam int PIX_W  = 8;
    // Linear address covers FRAME_W * FRAME_H words
    localparam int ADDR_W = 8;

    ////////////////////
    // Pass control
    ////////////////////

    // Even count so the final result sits in RAM 1
    localparam int NUM_PASSES = 4;
    localparam int PASS_W     = 3;

    typedef logic [PIX_W-1:0]  pixel_t;
    // Address is row * FRAME_W + column
    typedef logic [ADDR_W-1:0] addr_t;

endpackage

// File: rtl/frameRam.sv
`timescale 1ns/100ps

module frameRam (
    input  logic            clk,
    input  logic            cs,
    input  logic            we,
    input  ipguPkg::addr_t  addr,
    input  ipguPkg::pixel_t wrData,
    output ipguPkg::pixel_t rdData
);

    import ipguPkg::*;

    // One word per pixel of the frame
    pixel_t mem [FRAME_W*FRAME_H];

    ////////////////////
    // Single port
    ////////////////////

    // Write on cs and we, registered read on cs alone
    always_ff @(posedge clk) begin
        if (cs) begin
            if (we) begin
                mem[addr] <= wrData;
            end else begin
                rdData <= mem[addr];
            end
        end
    end

endmodule

// File: rtl/frameBank.sv
`timescale 1ns/100ps

module frameBank (
    input  logic            clk,
    input  logic            rst_n,
    // External port, RAM 1 only
    input  logic            csRam1Ext,
    input  logic            weRam1Ext,
    input  ipguPkg::addr_t  addrRam1Ext,
    input  ipguPkg::pixel_t wrDataRam1Ext,
    output ipguPkg::pixel_t rdDataRam1,
    // Pass side
    input  logic            srcSel,
    input  logic            rdEn,
    input  ipguPkg::addr_t  rdAddr,
    output ipguPkg::pixel_t srcPix,
    input  logic            wrEn,
    input  ipguPkg::addr_t  wrAddr,
    input  ipguPkg::pixel_t wrPix
);

    import ipguPkg::*;

    logic   cs1;
    logic   we1;
    addr_t  addr1;
    pixel_t wrData1;
    pixel_t rdData1;

    logic   cs2;
    logic   we2;
    addr_t  addr2;
    pixel_t wrData2;
    pixel_t rdData2;

    // Lines up with the one-cycle RAM read latency
    logic   srcSelQ;

    ////////////////////
    // Port steering
    ////////////////////

    always_comb begin
        if (srcSel) begin
            // RAM 2 is source, RAM 1 takes the writes
            cs1     = wrEn;
            we1     = wrEn;
            addr1   = wrAddr;
            wrData1 = wrPix;
            cs2     = rdEn;
            we2     = 1'b0;
            addr2   = rdAddr;
            wrData2 = '0;
        end else begin
            cs1     = rdEn;
            we1     = 1'b0;
            addr1   = rdAddr;
            wrData1 = '0;
            cs2     = wrEn;
            we2     = wrEn;
            addr2   = wrAddr;
            wrData2 = wrPix;
        end
        // Control unit access wins on RAM 1
        if (csRam1Ext) begin
            cs1     = 1'b1;
            we1     = weRam1Ext;
            addr1   = addrRam1Ext;
            wrData1 = wrDataRam1Ext;
        end
    end

    frameRam ram1 (
        .clk    (clk),
        .cs     (cs1),
        .we     (we1),
        .addr   (addr1),
        .wrData (wrData1),
        .rdData (rdData1)
    );

    frameRam ram2 (
        .clk    (clk),
        .cs     (cs2),
        .we     (we2),
        .addr   (addr2),
        .wrData (wrData2),
        .rdData (rdData2)
    );

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            srcSelQ <= 1'b0;
        end else begin
            srcSelQ <= srcSel;
        end
    end

    assign srcPix     = srcSelQ ? rdData2 : rdData1;
    assign rdDataRam1 = rdData1;

endmodule

// File: rtl/scanAddrGen.sv
`timescale 1ns/100ps

module scanAddrGen (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           scanStart,
    output logic           rdEn,
    output ipguPkg::addr_t rdAddr,
    output logic           firstCol,
    output logic           lastPix
);

    import ipguPkg::*;

    logic             active;
    logic [COL_W-1:0] col;
    logic [ROW_W-1:0] row;
    logic             colEnd;
    logic             rowEnd;

    assign colEnd = (col == COL_W'(FRAME_W - 1));
    assign rowEnd = (row == ROW_W'(FRAME_H - 1));

    ////////////////////
    // Raster counters
    ////////////////////

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            active <= 1'b0;
            col    <= '0;
            row    <= '0;
        end else if (scanStart) begin
            active <= 1'b1;
            col    <= '0;
            row    <= '0;
        end else if (active) begin
            if (colEnd) begin
                col <= '0;
                if (rowEnd) begin
                    // Frame done, wait for the next start
                    row    <= '0;
                    active <= 1'b0;
                end else begin
                    row <= row + 1'b1;
                end
            end else begin
                col <= col + 1'b1;
            end
        end
    end

    // One read per cycle while the scan is active
    assign rdEn     = active;
    assign rdAddr   = addr_t'(row * FRAME_W + col);
    assign firstCol = active && (col == '0);
    assign lastPix  = active && colEnd && rowEnd;

endmodule

// File: rtl/pixelSmoother.sv
`timescale 1ns/100ps

module pixelSmoother (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            rdEn,
    input  ipguPkg::addr_t  rdAddr,
    input  logic            firstCol,
    input  logic            lastPix,
    input  ipguPkg::pixel_t srcPix,
    output logic            wrEn,
    output ipguPkg::addr_t  wrAddr,
    output ipguPkg::pixel_t wrPix,
    output logic            wrLast
);

    import ipguPkg::*;

    // Address and flags aligned with srcPix
    logic   vldQ;
    addr_t  addrQ;
    logic   firstQ;
    logic   lastQ;

    pixel_t prevPix;
    // One extra bit so the sum cannot overflow
    logic [PIX_W:0] pixSum;

    ////////////////////
    // Align stage
    ////////////////////

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            vldQ   <= 1'b0;
            firstQ <= 1'b0;
            lastQ  <= 1'b0;
        end else begin
            vldQ   <= rdEn;
            firstQ <= firstCol;
            lastQ  <= lastPix;
        end
    end

    always_ff @(posedge clk) begin
        addrQ <= rdAddr;
    end

    assign pixSum = {1'b0, srcPix} + {1'b0, prevPix};

    ////////////////////
    // Output stage
    ////////////////////

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            wrEn   <= 1'b0;
            wrLast <= 1'b0;
        end else begin
            wrEn   <= vldQ;
            wrLast <= vldQ && lastQ;
        end
    end

    always_ff @(posedge clk) begin
        if (vldQ) begin
            // Row start passes through, otherwise floor average
            wrPix   <= firstQ ? srcPix : pixSum[PIX_W:1];
            wrAddr  <= addrQ;
            prevPix <= srcPix;
        end
    end

endmodule

// File: rtl/passSequencer.sv
`timescale 1ns/100ps

module passSequencer (
    input  logic clk,
    input  logic rst_n,
    // Control unit side
    input  logic initIpgu,
    output logic rdyIpgu,
    // HEU side
    input  logic rdyHeu,
    output logic vldIpgu,
    // Datapath
    input  logic wrLast,
    output logic scanStart,
    output logic srcSel
);

    import ipguPkg::*;

    typedef enum logic [1:0] {
        stIdle,
        stScan,
        stWaitHeu
    } state_t;

    state_t state;
    state_t nextState;

    logic [PASS_W-1:0] passCnt;
    logic              lastPass;
    logic              startScan;
    logic              passDone;

    assign lastPass = (passCnt == PASS_W'(NUM_PASSES - 1));
    // Pass closes on the handshake with the HEU
    assign passDone = (state == stWaitHeu) && rdyHeu;

    ////////////////////
    // Next state
    ////////////////////

    always_comb begin
        nextState = state;
        startScan = 1'b0;
        case (state)
            stIdle: begin
                if (initIpgu) begin
                    nextState = stScan;
                    startScan = 1'b1;
                end
            end
            stScan: begin
                // Last write of the pass is in the RAM
                if (wrLast) begin
                    nextState = stWaitHeu;
                end
            end
            stWaitHeu: begin
                if (rdyHeu) begin
                    if (lastPass) begin
                        nextState = stIdle;
                    end else begin
                        nextState = stScan;
                        startScan = 1'b1;
                    end
                end
            end
            default: begin
                nextState = stIdle;
            end
        endcase
    end

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            state     <= stIdle;
            scanStart <= 1'b0;
        end else begin
            state     <= nextState;
            scanStart <= startScan;
        end
    end

    ////////////////////
    // Pass counter
    ////////////////////

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            passCnt <= '0;
        end else if ((state == stIdle) && initIpgu) begin
            passCnt <= '0;
        end else if (passDone) begin
            passCnt <= passCnt + 1'b1;
        end
    end

    // Even passes read RAM 1, odd passes read RAM 2
    assign srcSel  = passCnt[0];
    assign rdyIpgu = (state == stIdle);
    assign vldIpgu = (state == stWaitHeu);

endmodule

// File: rtl/ipgu.sv
`timescale 1ns/100ps

module ipgu (
    input  logic            clk,
    input  logic            rst_n,
    // Control unit access to RAM 1
    input  logic            csRam1Ext,
    input  logic            weRam1Ext,
    input  ipguPkg::addr_t  addrRam1Ext,
    input  ipguPkg::pixel_t wrDataRam1Ext,
    output ipguPkg::pixel_t rdDataRam1,
    // Start and done
    input  logic            initIpgu,
    output logic            rdyIpgu,
    // HEU handshake
    input  logic            rdyHeu,
    output logic            vldIpgu
);

    import ipguPkg::*;

    logic   scanStart;
    logic   srcSel;

    // Read side of the scan
    logic   rdEn;
    addr_t  rdAddr;
    logic   firstCol;
    logic   lastPix;
    pixel_t srcPix;

    // Write side of the scan
    logic   wrEn;
    addr_t  wrAddr;
    pixel_t wrPix;
    logic   wrLast;

    passSequencer i_passSequencer (
        .clk       (clk),
        .rst_n     (rst_n),
        .initIpgu  (initIpgu),
        .rdyIpgu   (rdyIpgu),
        .rdyHeu    (rdyHeu),
        .vldIpgu   (vldIpgu),
        .wrLast    (wrLast),
        .scanStart (scanStart),
        .srcSel    (srcSel)
    );

    scanAddrGen i_scanAddrGen (
        .clk       (clk),
        .rst_n     (rst_n),
        .scanStart (scanStart),
        .rdEn      (rdEn),
        .rdAddr    (rdAddr),
        .firstCol  (firstCol),
        .lastPix   (lastPix)
    );

    frameBank i_frameBank (
        .clk           (clk),
        .rst_n         (rst_n),
        .csRam1Ext     (csRam1Ext),
        .weRam1Ext     (weRam1Ext),
        .addrRam1Ext   (addrRam1Ext),
        .wrDataRam1Ext (wrDataRam1Ext),
        .rdDataRam1    (rdDataRam1),
        .srcSel        (srcSel),
        .rdEn          (rdEn),
        .rdAddr        (rdAddr),
        .srcPix        (srcPix),
        .wrEn          (wrEn),
        .wrAddr        (wrAddr),
        .wrPix         (wrPix)
    );

    pixelSmoother i_pixelSmoother (
        .clk      (clk),
        .rst_n    (rst_n),
        .rdEn     (rdEn),
        .rdAddr   (rdAddr),
        .firstCol (firstCol),
        .lastPix  (lastPix),
        .srcPix   (srcPix),
        .wrEn     (wrEn),
        .wrAddr   (wrAddr),
        .wrPix    (wrPix),
        .wrLast   (wrLast)
    );

endmodule

// File: testbench/ipguTb.sv
`timescale 1ns/100ps

module ipguTb;

    import ipguPkg::*;

    localparam int NPIX       = FRAME_W * FRAME_H;
    // Random, zeros, 0xFF, checkerboard, then three random frames back to back
    localparam int NUM_FRAMES = 7;
    localparam int TIMEOUT_CYCLES = NUM_FRAMES * (NUM_PASSES * (NPIX + 20) + 1000);

    logic   clk;
    logic   rst_n;
    logic   csRam1Ext;
    logic   weRam1Ext;
    addr_t  addrRam1Ext;
    pixel_t wrDataRam1Ext;
    pixel_t rdDataRam1;
    logic   initIpgu;
    logic   rdyIpgu;
    logic   rdyHeu;
    logic   vldIpgu;

    integer seed = 32'h8c314cdf;

    // Frame as loaded, and the expected RAM 1 content after a run
    pixel_t frame [NPIX];
    pixel_t model [NPIX];

    ipgu i_ipgu (
        .clk           (clk),
        .rst_n         (rst_n),
        .csRam1Ext     (csRam1Ext),
        .weRam1Ext     (weRam1Ext),
        .addrRam1Ext   (addrRam1Ext),
        .wrDataRam1Ext (wrDataRam1Ext),
        .rdDataRam1    (rdDataRam1),
        .initIpgu      (initIpgu),
        .rdyIpgu       (rdyIpgu),
        .rdyHeu        (rdyHeu),
        .vldIpgu       (vldIpgu)
    );

    always #50 clk = ~clk;

    task automatic stopOnMismatch(input string msg);
        $display("MISMATCH at time %0t: %s", $time, msg);
        $display("Result: FAILED");
        $fatal(1, "Stopping at the first error");
    endtask

    task automatic stopOnError(input string msg);
        $display("ERROR at time %0t: %s", $time, msg);
        $display("Result: FAILED");
        $fatal(1, "Stopping at the first error");
    endtask

    ////////////////////
    // Frames and model
    ////////////////////

    task automatic fillFrame(input int kind);
        for (int i = 0; i < NPIX; i++) begin
            case (kind)
                1: frame[i] = 8'h00;
                2: frame[i] = 8'hFF;
                // 0 and 0xFF alternate along a row with the phase flipped every row
                3: frame[i] = (((i / FRAME_W) + (i % FRAME_W)) % 2) ? 8'hFF : 8'h00;
                default: frame[i] = pixel_t'($random(seed));
            endcase
        end
    endtask

    task automatic buildModel();
        pixel_t src [NPIX];
        int     sum;
        for (int i = 0; i < NPIX; i++) begin
            model[i] = frame[i];
        end
        for (int p = 0; p < NUM_PASSES; p++) begin
            for (int i = 0; i < NPIX; i++) begin
                src[i] = model[i];
            end
            for (int i = 0; i < NPIX; i++) begin
                if (i % FRAME_W == 0) begin
                    model[i] = src[i];
                end else begin
                    sum      = int'(src[i]) + int'(src[i-1]);
                    model[i] = pixel_t'(sum / 2);
                end
            end
        end
    endtask

    ////////////////////
    // External port
    ////////////////////

    task automatic loadFrame();
        for (int i = 0; i < NPIX; i++) begin
            @(posedge clk);
            csRam1Ext     <= 1'b1;
            weRam1Ext     <= 1'b1;
            addrRam1Ext   <= addr_t'(i);
            wrDataRam1Ext <= frame[i];
        end
        @(posedge clk);
        csRam1Ext <= 1'b0;
        weRam1Ext <= 1'b0;
    endtask

    // Read data of address i is sampled two edges after the address is driven
    task automatic readBack(input bit afterRun);
        pixel_t expected;
        for (int i = 0; i < NPIX + 2; i++) begin
            @(posedge clk);
            if (i >= 2) begin
                expected = afterRun ? model[i-2] : frame[i-2];
                assert (rdDataRam1 === expected)
                    else stopOnMismatch($sformatf("addr %0d expected %02h actual %02h",
                                                  i - 2, expected, rdDataRam1));
            end
            if (i < NPIX) begin
                csRam1Ext   <= 1'b1;
                weRam1Ext   <= 1'b0;
                addrRam1Ext <= addr_t'(i);
            end else begin
                csRam1Ext <= 1'b0;
            end
        end
    endtask

    ////////////////////
    // Run and HEU
    ////////////////////

    task automatic runPasses();
        int   vldRises;
        logic prevVld;
        logic prevHeu;
        logic done;
        vldRises = 0;
        prevVld  = 1'b0;
        prevHeu  = 1'b0;
        done     = 1'b0;
        @(posedge clk);
        initIpgu <= 1'b1;
        @(posedge clk);
        initIpgu <= 1'b0;
        while (!done) begin
            @(posedge clk);
            if (vldIpgu && !prevVld) begin
                vldRises++;
            end
            if (prevVld && !vldIpgu) begin
                assert (prevHeu === 1'b1)
                    else stopOnError("vldIpgu dropped without a rdyHeu answer");
            end
            prevVld = vldIpgu;
            prevHeu = rdyHeu;
            done    = rdyIpgu;
        end
        assert (vldIpgu === 1'b0)
            else stopOnError("rdyIpgu rose while vldIpgu still waited for the HEU");
        assert (vldRises == NUM_PASSES)
            else stopOnMismatch($sformatf("vldIpgu pulses expected %0d actual %0d",
                                          NUM_PASSES, vldRises));
    endtask

    // HEU answers each vldIpgu after 0 to 7 idle cycles
    always begin : heuResponder
        int delay;
        @(posedge clk);
        if (vldIpgu && !rdyHeu) begin
            delay = $unsigned($random(seed)) % 8;
            repeat (delay) @(posedge clk);
            rdyHeu <= 1'b1;
            @(posedge clk);
            rdyHeu <= 1'b0;
        end
    end

    initial begin : watchdog
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Run timed out after %0d cycles without finishing", TIMEOUT_CYCLES);
        $display("Result: FAILED");
        $fatal(1, "Watchdog expired");
    end

    initial begin
        clk           = 1'b0;
        rst_n         = 1'b0;
        csRam1Ext     = 1'b0;
        weRam1Ext     = 1'b0;
        addrRam1Ext   = '0;
        wrDataRam1Ext = '0;
        initIpgu      = 1'b0;
        rdyHeu        = 1'b0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        assert (rdyIpgu === 1'b1 && vldIpgu === 1'b0)
            else stopOnMismatch($sformatf("after reset rdyIpgu %b vldIpgu %b",
                                          rdyIpgu, vldIpgu));
        for (int f = 0; f < NUM_FRAMES; f++) begin
            fillFrame(f);
            loadFrame();
            readBack(1'b0);
            buildModel();
            runPasses();
            readBack(1'b1);
        end
        $display("Result: PASSED");
        $finish;
    end

endmodule

// File: files.f
rtl/ipguPkg.sv
rtl/frameRam.sv
rtl/frameBank.sv
rtl/scanAddrGen.sv
rtl/pixelSmoother.sv
rtl/passSequencer.sv
rtl/ipgu.sv
testbench/ipguTb.sv

// File: Bender.yml
package:
  name: ipgu

sources:
  - files:
      - rtl/ipguPkg.sv
      - rtl/frameRam.sv
      - rtl/frameBank.sv
      - rtl/scanAddrGen.sv
      - rtl/pixelSmoother.sv
      - rtl/passSequencer.sv
      - rtl/ipgu.sv
  - target: simulation
    files:
      - testbench/ipguTb.sv
